//--- debug_macros.svh
`ifndef DEBUG_MACROS_SVH
`define DEBUG_MACROS_SVH

// UART timing in clock cycles per bit
`define DBG_CLKS_PER_BIT 8

// Dump lengths
`define DBG_NUM_REGS 32
`define DBG_MEM_DUMP_WORDS 20

// Latch signals per pipeline stage, fetch to write-back
`define DBG_LATCH_STAGE0 2
`define DBG_LATCH_STAGE1 6
`define DBG_LATCH_STAGE2 6
`define DBG_LATCH_STAGE3 4
`define DBG_LATCH_STAGE4 2

`define DBG_HALT_WORD 32'h7FFFFFFE

`endif

//--- debug_pkg.sv
`default_nettype none

package debug_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // Stage in [6:4], signal index in [3:0]
    typedef logic [6:0]  latch_sel_t;

    typedef enum logic [1:0] {LD_MODE, LD_PROGRAM, LD_DONE} loader_state_t;

    typedef enum logic [2:0] {DS_IDLE, DS_PC, DS_REG, DS_MEM, DS_LATCH,
                              DS_CAPTURE, DS_WAIT_TX, DS_FINISH} dump_state_t;

endpackage

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_macros.svh"

module uart_rx (
    input  logic             clk,
    input  logic             rst,
    input  logic             rx,
    output debug_pkg::byte_t rx_byte,
    output logic             rx_byte_valid
);

    logic [1:0]       rx_sync;
    logic             busy;
    logic             sample;
    logic [3:0]       bit_cnt;
    logic [15:0]      clk_cnt;
    debug_pkg::byte_t shift;

    // Start bit checked after half a bit, every later bit after a full one
    assign sample = (bit_cnt == 4'd0) ? (clk_cnt == `DBG_CLKS_PER_BIT / 2 - 1)
                                      : (clk_cnt == `DBG_CLKS_PER_BIT - 1);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rx_sync       <= 2'b11;
            busy          <= 1'b0;
            bit_cnt       <= 4'd0;
            clk_cnt       <= '0;
            rx_byte_valid <= 1'b0;
        end
        else
        begin
            rx_sync       <= {rx_sync[0], rx};
            rx_byte_valid <= 1'b0;
            if (!busy)
            begin
                clk_cnt <= '0;
                bit_cnt <= 4'd0;
                busy    <= !rx_sync[1];
            end
            else if (sample)
            begin
                clk_cnt <= '0;
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd0)
                    busy <= !rx_sync[1];  // glitch, not a real start bit
                else if (bit_cnt == 4'd9)
                begin
                    busy          <= 1'b0;
                    rx_byte_valid <= rx_sync[1];
                end
            end
            else
                clk_cnt <= clk_cnt + 16'd1;
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk)
    begin
        if (busy && sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8)
            shift <= {rx_sync[1], shift[7:1]};
        if (busy && sample && bit_cnt == 4'd9)
            rx_byte <= shift;
    end

    assert property (@(posedge clk) disable iff (rst) rx_byte_valid |=> !rx_byte_valid);

endmodule

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_macros.svh"

module uart_tx (
    input  logic             clk,
    input  logic             rst,
    input  logic             tx_start,
    input  debug_pkg::byte_t tx_byte,
    output logic             tx,
    output logic             tx_busy,
    output logic             tx_done
);

    // Stop, data and start bits, shifted out from bit 0
    logic [9:0]  frame;
    logic [3:0]  bit_cnt;
    logic [15:0] clk_cnt;

    assign tx = frame[0];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            frame   <= '1;
            tx_busy <= 1'b0;
            tx_done <= 1'b0;
            bit_cnt <= 4'd0;
            clk_cnt <= '0;
        end
        else
        begin
            tx_done <= 1'b0;
            if (!tx_busy)
            begin
                if (tx_start)
                begin
                    frame   <= {1'b1, tx_byte, 1'b0};
                    tx_busy <= 1'b1;
                    bit_cnt <= 4'd0;
                    clk_cnt <= '0;
                end
            end
            else if (clk_cnt == `DBG_CLKS_PER_BIT - 1)
            begin
                clk_cnt <= '0;
                frame   <= {1'b1, frame[9:1]};
                bit_cnt <= bit_cnt + 4'd1;
                // End of the stop bit
                if (bit_cnt == 4'd9)
                begin
                    tx_busy <= 1'b0;
                    tx_done <= 1'b1;
                end
            end
            else
                clk_cnt <= clk_cnt + 16'd1;
        end
    end

    assert property (@(posedge clk) disable iff (rst) tx_start |-> !tx_busy);

endmodule

`default_nettype wire

//--- uart_word_link.sv
`timescale 1ns/1ps
`default_nettype none

module uart_word_link (
    input  logic             clk,
    input  logic             rst,
    input  logic             rx,
    output logic             tx,
    output debug_pkg::word_t rx_word,
    output logic             rx_word_valid,
    input  debug_pkg::word_t tx_word,
    input  logic             tx_word_start,
    output logic             tx_word_done
);

    debug_pkg::byte_t rx_byte;
    logic             rx_byte_valid;
    logic [1:0]       rx_cnt;
    logic [23:0]      rx_shift;
    debug_pkg::word_t tx_reg;
    logic [1:0]       tx_idx;
    logic             tx_byte_start;
    logic             tx_busy;
    logic             tx_byte_done;

    uart_rx i_uart_rx (
        .clk           (clk),
        .rst           (rst),
        .rx            (rx),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid)
    );

    uart_tx i_uart_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_byte_start),
        .tx_byte  (tx_reg[7:0]),
        .tx       (tx),
        .tx_busy  (tx_busy),
        .tx_done  (tx_byte_done)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Receive side, bytes come LSB first

    assign rx_word_valid = rx_byte_valid && (rx_cnt == 2'd3);
    assign rx_word       = {rx_byte, rx_shift};

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            rx_cnt <= 2'd0;
        else if (rx_byte_valid)
            rx_cnt <= rx_cnt + 2'd1;
    end

    always_ff @(posedge clk)
    begin
        if (rx_byte_valid)
            rx_shift <= {rx_byte, rx_shift[23:8]};
    end

    ////////////////////////////////////////////////////////////////////////////
    // Transmit side, next byte starts on the previous byte's done pulse

    assign tx_word_done = tx_byte_done && (tx_idx == 2'd3);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tx_idx        <= 2'd0;
            tx_byte_start <= 1'b0;
        end
        else
        begin
            tx_byte_start <= 1'b0;
            if (tx_word_start)
            begin
                tx_idx        <= 2'd0;
                tx_byte_start <= 1'b1;
            end
            else if (tx_byte_done && tx_idx != 2'd3)
            begin
                tx_idx        <= tx_idx + 2'd1;
                tx_byte_start <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (tx_word_start)
            tx_reg <= tx_word;
        else if (tx_byte_done)
            tx_reg <= {8'h00, tx_reg[31:8]};
    end

    // The sequencer never starts a word while a byte is queued or on the line
    assert property (@(posedge clk) disable iff (rst)
        tx_word_start |-> !tx_busy && !tx_byte_start);

endmodule

`default_nettype wire

//--- program_loader.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_macros.svh"

module program_loader (
    input  logic             clk,
    input  logic             rst,
    input  debug_pkg::word_t rx_word,
    input  logic             rx_word_valid,
    output logic             prog_write,
    output debug_pkg::word_t prog_address,
    output debug_pkg::word_t prog_instruction,
    output logic             loading,
    output logic             step_mode,
    output logic             load_done,
    output debug_pkg::word_t last_address
);

    debug_pkg::loader_state_t state;

    assign load_done = (state == debug_pkg::LD_DONE);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state        <= debug_pkg::LD_MODE;
            prog_write   <= 1'b0;
            loading      <= 1'b0;
            step_mode    <= 1'b0;
            last_address <= '0;
        end
        else
        begin
            prog_write <= 1'b0;
            case (state)
                debug_pkg::LD_MODE:
                begin
                    loading <= 1'b1;
                    if (rx_word_valid)
                    begin
                        step_mode <= rx_word[0];
                        state     <= debug_pkg::LD_PROGRAM;
                    end
                end
                debug_pkg::LD_PROGRAM:
                begin
                    if (rx_word_valid && rx_word == `DBG_HALT_WORD)
                    begin
                        loading <= 1'b0;
                        state   <= debug_pkg::LD_DONE;
                    end
                    else if (rx_word_valid)
                    begin
                        prog_write   <= 1'b1;
                        last_address <= last_address + 32'd1;
                    end
                end
                default:
                    loading <= 1'b0;
            endcase
        end
    end

    // Write data, qualified by prog_write
    always_ff @(posedge clk)
    begin
        if (state == debug_pkg::LD_PROGRAM && rx_word_valid)
        begin
            prog_address     <= last_address;
            prog_instruction <= rx_word;
        end
    end

endmodule

`default_nettype wire

//--- state_dump_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_macros.svh"

module state_dump_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  step_mode,
    input  logic                  load_done,
    input  debug_pkg::word_t      last_address,
    input  logic                  rx_word_valid,
    input  debug_pkg::word_t      pc,
    input  debug_pkg::word_t      reg_data,
    input  debug_pkg::word_t      mem_data,
    input  debug_pkg::word_t      latch_data,
    output debug_pkg::word_t      debug_address,
    output debug_pkg::latch_sel_t latch_select,
    output debug_pkg::word_t      tx_word,
    output logic                  tx_word_start,
    input  logic                  tx_word_done,
    output logic                  debug_active,
    output logic                  pc_stall
);

    debug_pkg::dump_state_t state;
    debug_pkg::dump_state_t item;
    logic [2:0]             stage;
    logic [3:0]             sig;

    function automatic logic [3:0] group_size(input logic [2:0] stg);
        case (stg)
            3'd0:    group_size = 4'(`DBG_LATCH_STAGE0);
            3'd1:    group_size = 4'(`DBG_LATCH_STAGE1);
            3'd2:    group_size = 4'(`DBG_LATCH_STAGE2);
            3'd3:    group_size = 4'(`DBG_LATCH_STAGE3);
            default: group_size = 4'(`DBG_LATCH_STAGE4);
        endcase
    endfunction

    assign latch_select = {stage, sig};

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state         <= debug_pkg::DS_IDLE;
            item          <= debug_pkg::DS_IDLE;
            stage         <= 3'd0;
            sig           <= 4'd0;
            debug_address <= '0;
            tx_word_start <= 1'b0;
            debug_active  <= 1'b0;
            pc_stall      <= 1'b0;
        end
        else
        begin
            tx_word_start <= 1'b0;
            case (state)
                debug_pkg::DS_IDLE:
                begin
                    if (load_done)
                    begin
                        pc_stall <= step_mode;
                        // Run mode fires once PC passes the last loaded instruction
                        if (step_mode ? rx_word_valid : (pc == {last_address[29:0], 2'b00}))
                        begin
                            state         <= debug_pkg::DS_PC;
                            debug_active  <= 1'b1;
                            pc_stall      <= 1'b1;
                            debug_address <= '0;
                            stage         <= 3'd0;
                            sig           <= 4'd0;
                        end
                    end
                end
                // Address or selector is on the bus during this cycle
                debug_pkg::DS_PC, debug_pkg::DS_REG, debug_pkg::DS_MEM, debug_pkg::DS_LATCH:
                begin
                    item  <= state;
                    state <= debug_pkg::DS_CAPTURE;
                end
                debug_pkg::DS_CAPTURE:
                begin
                    tx_word_start <= 1'b1;
                    state         <= debug_pkg::DS_WAIT_TX;
                end
                debug_pkg::DS_WAIT_TX:
                begin
                    if (tx_word_done)
                    begin
                        case (item)
                            debug_pkg::DS_PC:
                                state <= debug_pkg::DS_REG;
                            debug_pkg::DS_REG:
                            begin
                                if (debug_address == `DBG_NUM_REGS - 1)
                                begin
                                    debug_address <= '0;
                                    state         <= debug_pkg::DS_MEM;
                                end
                                else
                                begin
                                    debug_address <= debug_address + 32'd1;
                                    state         <= debug_pkg::DS_REG;
                                end
                            end
                            debug_pkg::DS_MEM:
                            begin
                                if (debug_address == `DBG_MEM_DUMP_WORDS - 1)
                                begin
                                    debug_address <= '0;
                                    state         <= debug_pkg::DS_LATCH;
                                end
                                else
                                begin
                                    debug_address <= debug_address + 32'd1;
                                    state         <= debug_pkg::DS_MEM;
                                end
                            end
                            default:
                            begin
                                // Walk the latch groups stage by stage
                                if (sig != group_size(stage) - 4'd1)
                                begin
                                    sig   <= sig + 4'd1;
                                    state <= debug_pkg::DS_LATCH;
                                end
                                else if (stage != 3'd4)
                                begin
                                    sig   <= 4'd0;
                                    stage <= stage + 3'd1;
                                    state <= debug_pkg::DS_LATCH;
                                end
                                else
                                begin
                                    sig   <= 4'd0;
                                    stage <= 3'd0;
                                    state <= debug_pkg::DS_FINISH;
                                end
                            end
                        endcase
                    end
                end
                default:
                begin
                    debug_active <= 1'b0;
                    // Step mode releases the PC for one cycle, run mode stays here
                    if (step_mode)
                    begin
                        pc_stall <= 1'b0;
                        state    <= debug_pkg::DS_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == debug_pkg::DS_CAPTURE)
        begin
            case (item)
                debug_pkg::DS_PC:  tx_word <= pc;
                debug_pkg::DS_REG: tx_word <= reg_data;
                debug_pkg::DS_MEM: tx_word <= mem_data;
                default:           tx_word <= latch_data;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        state == debug_pkg::DS_REG |-> debug_address < `DBG_NUM_REGS);

endmodule

`default_nettype wire

//--- debug_unit.sv
`timescale 1ns/1ps
`default_nettype none

module debug_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rx,
    output logic                  tx,
    input  debug_pkg::word_t      pc,
    input  debug_pkg::word_t      reg_data,
    input  debug_pkg::word_t      mem_data,
    input  debug_pkg::word_t      latch_data,
    output debug_pkg::word_t      debug_address,
    output debug_pkg::latch_sel_t latch_select,
    output logic                  prog_write,
    output debug_pkg::word_t      prog_address,
    output debug_pkg::word_t      prog_instruction,
    output logic                  loading,
    output logic                  debug_active,
    output logic                  step_mode_led,
    output logic                  pc_stall
);

    debug_pkg::word_t rx_word;
    logic             rx_word_valid;
    debug_pkg::word_t tx_word;
    logic             tx_word_start;
    logic             tx_word_done;
    logic             load_done;
    debug_pkg::word_t last_address;

    uart_word_link i_uart_word_link (
        .clk           (clk),
        .rst           (rst),
        .rx            (rx),
        .tx            (tx),
        .rx_word       (rx_word),
        .rx_word_valid (rx_word_valid),
        .tx_word       (tx_word),
        .tx_word_start (tx_word_start),
        .tx_word_done  (tx_word_done)
    );

    program_loader i_program_loader (
        .clk              (clk),
        .rst              (rst),
        .rx_word          (rx_word),
        .rx_word_valid    (rx_word_valid),
        .prog_write       (prog_write),
        .prog_address     (prog_address),
        .prog_instruction (prog_instruction),
        .loading          (loading),
        .step_mode        (step_mode_led),
        .load_done        (load_done),
        .last_address     (last_address)
    );

    state_dump_sequencer i_state_dump_sequencer (
        .clk           (clk),
        .rst           (rst),
        .step_mode     (step_mode_led),
        .load_done     (load_done),
        .last_address  (last_address),
        .rx_word_valid (rx_word_valid),
        .pc            (pc),
        .reg_data      (reg_data),
        .mem_data      (mem_data),
        .latch_data    (latch_data),
        .debug_address (debug_address),
        .latch_select  (latch_select),
        .tx_word       (tx_word),
        .tx_word_start (tx_word_start),
        .tx_word_done  (tx_word_done),
        .debug_active  (debug_active),
        .pc_stall      (pc_stall)
    );

endmodule

`default_nettype wire

//--- tb_debug_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "debug_macros.svh"

module tb_debug_unit;

    localparam int PROG_LEN    = 5;
    localparam int LATCH_WORDS = `DBG_LATCH_STAGE0 + `DBG_LATCH_STAGE1 + `DBG_LATCH_STAGE2
                               + `DBG_LATCH_STAGE3 + `DBG_LATCH_STAGE4;
    localparam int DUMP_WORDS  = 1 + `DBG_NUM_REGS + `DBG_MEM_DUMP_WORDS + LATCH_WORDS;
    localparam int WORD_CYCLES = 45 * `DBG_CLKS_PER_BIT;
    // Three dumps, the host words of both loads and steps, and slack for idle checks
    localparam int WATCHDOG_CYCLES = (3 * DUMP_WORDS + 20) * WORD_CYCLES + 2000;

    logic                  clk;
    logic                  rst;
    logic                  rx;
    logic                  tx;
    debug_pkg::word_t      pc;
    debug_pkg::word_t      reg_data;
    debug_pkg::word_t      mem_data;
    debug_pkg::word_t      latch_data;
    debug_pkg::word_t      debug_address;
    debug_pkg::latch_sel_t latch_select;
    logic                  prog_write;
    debug_pkg::word_t      prog_address;
    debug_pkg::word_t      prog_instruction;
    logic                  loading;
    logic                  debug_active;
    logic                  step_mode_led;
    logic                  pc_stall;

    integer           seed = 59;
    int               latch_sizes [5] = '{`DBG_LATCH_STAGE0, `DBG_LATCH_STAGE1,
                                          `DBG_LATCH_STAGE2, `DBG_LATCH_STAGE3,
                                          `DBG_LATCH_STAGE4};
    debug_pkg::word_t wr_addr [$];
    debug_pkg::word_t wr_data [$];

    debug_unit i_debug_unit (
        .clk              (clk),
        .rst              (rst),
        .rx               (rx),
        .tx               (tx),
        .pc               (pc),
        .reg_data         (reg_data),
        .mem_data         (mem_data),
        .latch_data       (latch_data),
        .debug_address    (debug_address),
        .latch_select     (latch_select),
        .prog_write       (prog_write),
        .prog_address     (prog_address),
        .prog_instruction (prog_instruction),
        .loading          (loading),
        .debug_active     (debug_active),
        .step_mode_led    (step_mode_led),
        .pc_stall         (pc_stall)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Processor model answers reads in the same cycle

    assign reg_data   = 32'hA000_0000 + debug_address;
    assign mem_data   = 32'hB000_0000 + debug_address;
    assign latch_data = 32'hC000_0000 + {25'd0, latch_select};

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the debug unit did not finish the tests in time");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    // Instruction memory writes seen by the processor
    always @(negedge clk)
    begin
        if (prog_write)
        begin
            wr_addr.push_back(prog_address);
            wr_data.push_back(prog_instruction);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "debug unit test stopped");
    endtask

    task automatic check_word(input string name, input debug_pkg::word_t got,
                              input debug_pkg::word_t exp);
        if (got !== exp)
            fail_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_sel(input string name, input debug_pkg::latch_sel_t got,
                             input debug_pkg::latch_sel_t exp);
        if (got !== exp)
            fail_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Host UART model

    task automatic send_byte(input debug_pkg::byte_t b);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++)
        begin
            @(posedge clk);
            rx <= frame[i];
            repeat (`DBG_CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic send_word(input debug_pkg::word_t w);
        int k;
        for (k = 0; k < 4; k++)
            send_byte(w[8 * k +: 8]);
    endtask

    // Samples tx in the middle of each bit
    task automatic receive_byte(output debug_pkg::byte_t b);
        int i;
        while (tx !== 1'b0)
            @(negedge clk);
        repeat (`DBG_CLKS_PER_BIT / 2) @(negedge clk);
        if (tx !== 1'b0)
            fail_run("Start bit on tx did not last to its middle");
        for (i = 0; i < 8; i++)
        begin
            repeat (`DBG_CLKS_PER_BIT) @(negedge clk);
            b[i] = tx;
        end
        repeat (`DBG_CLKS_PER_BIT) @(negedge clk);
        if (tx !== 1'b1)
            fail_run("Stop bit on tx is missing");
    endtask

    task automatic receive_word(output debug_pkg::word_t w);
        debug_pkg::byte_t b;
        int               k;
        for (k = 0; k < 4; k++)
        begin
            receive_byte(b);
            w[8 * k +: 8] = b;
        end
    endtask

    task automatic receive_dump(input debug_pkg::word_t exp_pc);
        debug_pkg::word_t      w;
        debug_pkg::latch_sel_t sel;
        int                    i;
        int                    s;
        int                    k;
        receive_word(w);
        check_word("pc", w, exp_pc);
        for (i = 0; i < `DBG_NUM_REGS; i++)
        begin
            receive_word(w);
            check_word("reg_data", w, 32'hA000_0000 + 32'(i));
        end
        for (i = 0; i < `DBG_MEM_DUMP_WORDS; i++)
        begin
            receive_word(w);
            check_word("mem_data", w, 32'hB000_0000 + 32'(i));
        end
        for (s = 0; s < 5; s++)
        begin
            for (k = 0; k < latch_sizes[s]; k++)
            begin
                sel = {s[2:0], k[3:0]};
                receive_word(w);
                // Selector is still held until the word's last stop bit ends
                check_sel("latch_select", latch_select, sel);
                check_word("latch_data", w, 32'hC000_0000 + {25'd0, sel});
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Helpers for the tests

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        wr_addr.delete();
        wr_data.delete();
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            check_bit("tx", tx, 1'b1);
            check_bit("debug_active", debug_active, 1'b0);
        end
    endtask

    // In step mode the PC is let go for one cycle as the dump ends
    task automatic wait_dump_end(input logic step);
        int n;
        n = 0;
        while (debug_active !== 1'b0)
        begin
            if (n == 4 * `DBG_CLKS_PER_BIT)
                fail_run("debug_active did not fall after the last dump word");
            @(negedge clk);
            n++;
        end
        if (step)
        begin
            check_bit("pc_stall", pc_stall, 1'b0);
            @(negedge clk);
            check_bit("pc_stall", pc_stall, 1'b1);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_program_load(input logic mode);
        debug_pkg::word_t instr [PROG_LEN];
        int               i;
        // Low straight out of reset, high once the loader runs
        @(negedge clk);
        check_bit("loading", loading, 1'b0);
        @(negedge clk);
        check_bit("loading", loading, 1'b1);
        send_word({31'd0, mode});
        for (i = 0; i < PROG_LEN; i++)
        begin
            instr[i] = $random(seed);
            if (instr[i] == `DBG_HALT_WORD)
                instr[i] = 32'h0000_0013;
            send_word(instr[i]);
        end
        send_word(`DBG_HALT_WORD);
        repeat (4) @(negedge clk);
        check_bit("loading", loading, 1'b0);
        check_bit("step_mode_led", step_mode_led, mode);
        check_word("prog_write count", 32'(wr_addr.size()), 32'(PROG_LEN));
        for (i = 0; i < PROG_LEN; i++)
        begin
            check_word("prog_address", wr_addr[i], 32'(i));
            check_word("prog_instruction", wr_data[i], instr[i]);
        end
    endtask

    task automatic test_run_trigger();
        int p;
        for (p = 0; p < 4 * PROG_LEN; p += 4)
        begin
            @(posedge clk);
            pc <= 32'(p);
            expect_quiet(4 * `DBG_CLKS_PER_BIT);
        end
        @(posedge clk);
        pc <= 32'(4 * PROG_LEN);
        @(negedge clk);
        @(negedge clk);
        check_bit("debug_active", debug_active, 1'b1);
    endtask

    task automatic test_dump_content();
        receive_dump(32'(4 * PROG_LEN));
    endtask

    task automatic test_run_finish();
        wait_dump_end(1'b0);
        send_word(32'h0000_0001);
        expect_quiet(2 * WORD_CYCLES);
        check_word("prog_write count", 32'(wr_addr.size()), 32'(PROG_LEN));
    endtask

    task automatic test_single_step();
        int s;
        test_program_load(1'b1);
        expect_quiet(2 * WORD_CYCLES);
        check_bit("pc_stall", pc_stall, 1'b1);
        for (s = 0; s < 2; s++)
        begin
            @(posedge clk);
            pc <= 32'h0000_0100 + 32'(4 * s);
            fork
                send_word($random(seed));
                receive_dump(32'h0000_0100 + 32'(4 * s));
            join
            wait_dump_end(1'b1);
        end
    endtask

    initial
    begin
        rst = 1'b1;
        rx  = 1'b1;
        pc  = '0;
        apply_reset();
        test_program_load(1'b0);
        test_run_trigger();
        test_dump_content();
        test_run_finish();
        apply_reset();
        test_single_step();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+.
debug_pkg.sv
uart_rx.sv
uart_tx.sv
uart_word_link.sv
program_loader.sv
state_dump_sequencer.sv
debug_unit.sv
tb_debug_unit.sv

//--- Makefile
SIM      = verilator
TOP      = tb_debug_unit
FILELIST = project.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
LINT     = --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
